/* design/aluPkg.sv */
`default_nettype none

package aluPkg;

  // datapath and register file geometry
  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 5;
  localparam int numRegs      = 32;

  // operations the ALU understands; 3'b111 is left unused
  typedef enum logic [2:0] {
    opAdd = 3'd0, // two's-complement add with signed overflow
    opSub = 3'd1, // a minus b done as a + ~b + 1
    opSlt = 3'd2, // signed set-on-less-than
    opAnd = 3'd3,
    opOr  = 3'd4,
    opXor = 3'd5,
    opNor = 3'd6
  } aluOp;

endpackage

`default_nettype wire

/* design/instrPkg.sv */
`default_nettype none

package instrPkg;

  // opcode field values
  localparam logic [5:0] opcodeR    = 6'h00; // register-register format where funct picks the operation
  localparam logic [5:0] opcodeAddi = 6'h08;
  localparam logic [5:0] opcodeSlti = 6'h0a;

  // funct field values that only matter under opcodeR
  localparam logic [5:0] functAdd = 6'h20;
  localparam logic [5:0] functSub = 6'h22;
  localparam logic [5:0] functAnd = 6'h24;
  localparam logic [5:0] functOr  = 6'h25;
  localparam logic [5:0] functXor = 6'h26;
  localparam logic [5:0] functNor = 6'h27;
  localparam logic [5:0] functSlt = 6'h2a;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rd;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] unused; // must be ignored by the decoder
    logic [5:0] funct;
  } rFormat;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  rs;
    logic [15:0] imm; // sign-extended before use
  } iFormat;

  // opcode, rd and rs sit in the same bits in both views
  typedef union packed {
    rFormat rType;
    iFormat iType;
  } instrWord;

endpackage

`default_nettype wire

/* design/rippleAdder.sv */
`default_nettype none

module rippleAdder
  import aluPkg::*;
(
  input  logic [dataWidth-1:0] a,
  input  logic [dataWidth-1:0] b,
  input  logic                 subtract,
  output logic [dataWidth-1:0] sum,
  output logic                 overflow
);

  logic [dataWidth-1:0] bIn;
  logic [dataWidth:0]   carry; // carry[k] is the carry into bit k

  // subtraction is a + ~b + 1, so the inversion and the carry in share one control
  assign bIn      = b ^ {dataWidth{subtract}};
  assign carry[0] = subtract;

  genvar bitIdx;
  for (bitIdx = 0; bitIdx < dataWidth; bitIdx++) begin : gBit
    logic halfSum;

    assign halfSum = a[bitIdx] ^ bIn[bitIdx];
    assign sum[bitIdx] = halfSum ^ carry[bitIdx];
    // generate when both bits are set, propagate an incoming carry when exactly one is
    assign carry[bitIdx+1] = (a[bitIdx] & bIn[bitIdx]) | (halfSum & carry[bitIdx]);
  end

  // signed overflow when the carries into and out of the sign bit disagree
  assign overflow = carry[dataWidth] ^ carry[dataWidth-1];

endmodule

`default_nettype wire

/* design/alu.sv */
`default_nettype none

module alu
  import aluPkg::*;
(
  input  aluOp                 op,
  input  logic [dataWidth-1:0] opA,
  input  logic [dataWidth-1:0] opB,
  output logic [dataWidth-1:0] y,
  output logic                 ovf
);

  logic                 subtract;
  logic [dataWidth-1:0] sum;
  logic                 adderOvf;
  logic                 lessThan;

  // slt needs the difference, so it shares the subtract path with sub
  assign subtract = (op == opSub) || (op == opSlt);

  rippleAdder i_adder (
    .a        (opA),
    .b        (opB),
    .subtract (subtract),
    .sum      (sum),
    .overflow (adderOvf)
  );

  // the sign of a - b is wrong exactly when the subtraction overflowed
  assign lessThan = sum[dataWidth-1] ^ adderOvf;

  always_comb begin
    y   = '0;
    ovf = 1'b0;
    case (op)
      opAdd: begin
        y   = sum;
        ovf = adderOvf;
      end
      opSub: begin
        y   = sum;
        ovf = adderOvf;
      end
      opSlt: begin
        y[0] = lessThan; // upper bits stay zero
      end
      opAnd: begin
        y = opA & opB;
      end
      opOr: begin
        y = opA | opB;
      end
      opXor: begin
        y = opA ^ opB;
      end
      opNor: begin
        y = ~(opA | opB);
      end
      default: begin
        y   = '0;
        ovf = 1'b0;
      end
    endcase
  end

  // the decoder upstream must never hand over the spare encoding
  always_comb begin
    opDefined: assert (op inside {opAdd, opSub, opSlt, opAnd, opOr, opXor, opNor})
      else $error("alu received undefined operation %0d", op);
  end

endmodule

`default_nettype wire

/* design/regFile.sv */
`default_nettype none

module regFile
  import aluPkg::*;
(
  input  logic                    clk,
  input  logic                    rstN,
  input  logic [regAddrWidth-1:0] raddrA,
  input  logic [regAddrWidth-1:0] raddrB,
  output logic [dataWidth-1:0]    rdataA,
  output logic [dataWidth-1:0]    rdataB,
  input  logic                    we,
  input  logic [regAddrWidth-1:0] waddr,
  input  logic [dataWidth-1:0]    wdata
);

  logic [dataWidth-1:0] regs [numRegs];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int idx = 0; idx < numRegs; idx++) begin
        regs[idx] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // register 0 is hardwired to zero whatever the array holds
  assign rdataA = (raddrA == '0) ? '0 : regs[raddrA];
  assign rdataB = (raddrB == '0) ? '0 : regs[raddrB];

  // the core must hold its write strobe off while the file is being cleared
  weInReset: assert property (@(posedge clk) !rstN |-> !we)
    else $error("regFile write strobe high during reset");

endmodule

`default_nettype wire

/* design/execCore.sv */
`default_nettype none

module execCore
  import aluPkg::*;
  import instrPkg::*;
(
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 instrValid,
  input  instrWord             instr,
  output logic                 resultValid,
  output logic [dataWidth-1:0] result,
  output logic                 overflow,
  output logic                 illegal
);

  logic [dataWidth-1:0]    rdataA;
  logic [dataWidth-1:0]    rdataB;
  logic [dataWidth-1:0]    immExt;
  logic [dataWidth-1:0]    opB;
  logic [dataWidth-1:0]    y;
  logic                    ovf;
  logic                    legal;
  logic                    useImm;
  aluOp                    op;
  logic                    we;
  logic [regAddrWidth-1:0] rd;

  // the opcode decides which view of the word is meaningful
  always_comb begin
    legal  = 1'b0;
    useImm = 1'b0;
    op     = opAdd;
    case (instr.rType.opcode)
      opcodeR: begin
        legal = 1'b1;
        case (instr.rType.funct)
          functAdd: op = opAdd;
          functSub: op = opSub;
          functSlt: op = opSlt;
          functAnd: op = opAnd;
          functOr:  op = opOr;
          functXor: op = opXor;
          functNor: op = opNor;
          default:  legal = 1'b0;
        endcase
      end
      opcodeAddi: begin
        legal  = 1'b1;
        useImm = 1'b1;
        op     = opAdd;
      end
      opcodeSlti: begin
        legal  = 1'b1;
        useImm = 1'b1;
        op     = opSlt;
      end
      default: legal = 1'b0;
    endcase
  end

  assign rd     = instr.rType.rd; // same bits in either format
  assign immExt = {{(dataWidth - 16){instr.iType.imm[15]}}, instr.iType.imm};
  assign opB    = useImm ? immExt : rdataB;

  // write-back lands at the accepting edge, so the next instruction reads it
  assign we = rstN && instrValid && legal && (rd != '0);

  regFile i_regFile (
    .clk    (clk),
    .rstN   (rstN),
    .raddrA (instr.rType.rs),
    .raddrB (instr.rType.rt),
    .rdataA (rdataA),
    .rdataB (rdataB),
    .we     (we),
    .waddr  (rd),
    .wdata  (y)
  );

  alu i_alu (
    .op  (op),
    .opA (rdataA),
    .opB (opB),
    .y   (y),
    .ovf (ovf)
  );

  always_ff @(posedge clk) begin
    if (!rstN) begin
      resultValid <= 1'b0;
      illegal     <= 1'b0;
      result      <= '0;
      overflow    <= 1'b0;
    end else begin
      resultValid <= instrValid && legal;
      illegal     <= instrValid && !legal;
      if (instrValid && legal) begin
        result   <= y; // held until the next legal instruction
        overflow <= ovf;
      end
    end
  end

  oneStrobe: assert property (@(posedge clk) disable iff (!rstN) !(resultValid && illegal))
    else $error("resultValid and illegal raised together");

endmodule

`default_nettype wire

/* tb/clockGen.sv */
`default_nettype none

module clockGen (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always begin
    #20 clk = ~clk; // period of 40
  end

endmodule

`default_nettype wire

/* tb/execCoreTb.sv */
`default_nettype none

module execCoreTb
  import aluPkg::*;
  import instrPkg::*;
();

  logic                 clk;
  logic                 rstN;
  logic                 instrValid;
  instrWord             instr;
  logic                 resultValid;
  logic [dataWidth-1:0] result;
  logic                 overflow;
  logic                 illegal;

  logic [dataWidth-1:0] modelRegs [numRegs];
  logic                 expValid;
  logic                 expIllegal;
  logic [dataWidth-1:0] expResult; // held like the DUT's result register
  logic                 expOvf;
  logic                 prevValid;
  logic                 prevIllegal;
  logic [dataWidth-1:0] prevResult;
  logic                 prevOvf;
  logic [31:0]          lfsrState;
  int                   mismatchCount;
  int                   timeoutCount;

  clockGen i_clockGen (
    .clk (clk)
  );

  execCore i_dut (
    .clk         (clk),
    .rstN        (rstN),
    .instrValid  (instrValid),
    .instr       (instr),
    .resultValid (resultValid),
    .result      (result),
    .overflow    (overflow),
    .illegal     (illegal)
  );

  // the DUT answers one edge after it accepts, so the expectation is delayed by one edge
  always @(posedge clk) begin
    prevValid   <= expValid;
    prevIllegal <= expIllegal;
    prevResult  <= expResult;
    prevOvf     <= expOvf;
  end

  strobeCheck: assert property (@(posedge clk) disable iff (!rstN)
      (resultValid == prevValid) && (illegal == prevIllegal))
    else begin
      mismatchCount++;
      $display("Mismatch at time %0t: resultValid %b illegal %b, expected %b %b",
               $time, $sampled(resultValid), $sampled(illegal),
               $sampled(prevValid), $sampled(prevIllegal));
    end

  dataCheck: assert property (@(posedge clk) disable iff (!rstN)
      (result == prevResult) && (overflow == prevOvf))
    else begin
      mismatchCount++;
      $display("Mismatch at time %0t: result %h overflow %b, expected %h %b",
               $time, $sampled(result), $sampled(overflow),
               $sampled(prevResult), $sampled(prevOvf));
    end

  // taps 32, 22, 2 and 1
  function automatic logic lfsrStep();
    logic fb;
    fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
    lfsrState = {lfsrState[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] randBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], lfsrStep()};
    end
    return value;
  endfunction

  function automatic logic [4:0] randReg();
    logic [31:0] bits;
    bits = randBits(5);
    return bits[4:0];
  endfunction

  function automatic logic [15:0] randImm();
    logic [31:0] bits;
    bits = randBits(16);
    return bits[15:0];
  endfunction

  function automatic aluOp randLogicOp();
    logic [31:0] bits;
    bits = randBits(2);
    case (bits[1:0])
      2'd0: return opAnd;
      2'd1: return opOr;
      2'd2: return opXor;
      default: return opNor;
    endcase
  endfunction

  function automatic aluOp randAnyOp();
    logic [31:0] bits;
    logic [2:0]  idx;
    bits = randBits(3);
    idx  = bits[2:0];
    if (idx == 3'd7) begin
      idx = 3'd0; // fold the spare code back onto add
    end
    return aluOp'(idx);
  endfunction

  // returns {overflow, value}; overflow follows the sign rules of two's complement
  function automatic logic [32:0] modelAlu(input aluOp op, input logic [31:0] a,
                                           input logic [31:0] b);
    logic [31:0] y;
    logic        ovf;
    ovf = 1'b0;
    case (op)
      opAdd: begin
        y   = a + b;
        ovf = (a[31] == b[31]) && (y[31] != a[31]); // overflow when like signs give a flipped sign
      end
      opSub: begin
        y   = a - b;
        ovf = (a[31] != b[31]) && (y[31] != a[31]);
      end
      opSlt: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      opAnd: y = a & b;
      opOr:  y = a | b;
      opXor: y = a ^ b;
      default: y = ~(a | b);
    endcase
    return {ovf, y};
  endfunction

  function automatic logic [5:0] functFor(input aluOp op);
    case (op)
      opAdd: return functAdd;
      opSub: return functSub;
      opSlt: return functSlt;
      opAnd: return functAnd;
      opOr:  return functOr;
      opXor: return functXor;
      default: return functNor;
    endcase
  endfunction

  task automatic present(input instrWord word, input logic legal, input logic [4:0] rd,
                         input logic [32:0] outcome);
    @(negedge clk);
    instrValid = 1'b1;
    instr      = word;
    expValid   = legal;
    expIllegal = !legal;
    if (legal) begin
      expResult = outcome[31:0];
      expOvf    = outcome[32];
      if (rd != 5'd0) begin
        modelRegs[rd] = outcome[31:0]; // lands at the accepting edge
      end
    end
  endtask

  task automatic issueR(input aluOp op, input logic [4:0] rd, input logic [4:0] rs,
                        input logic [4:0] rt);
    instrWord word;
    word              = '0;
    word.rType.opcode = opcodeR;
    word.rType.rd     = rd;
    word.rType.rs     = rs;
    word.rType.rt     = rt;
    word.rType.funct  = functFor(op);
    present(word, 1'b1, rd, modelAlu(op, modelRegs[rs], modelRegs[rt]));
  endtask

  task automatic issueI(input aluOp op, input logic [4:0] rd, input logic [4:0] rs,
                        input logic [15:0] imm);
    instrWord    word;
    logic [31:0] immExt;
    immExt            = {{16{imm[15]}}, imm};
    word              = '0;
    word.iType.opcode = (op == opSlt) ? opcodeSlti : opcodeAddi;
    word.iType.rd     = rd;
    word.iType.rs     = rs;
    word.iType.imm    = imm;
    present(word, 1'b1, rd, modelAlu(op, modelRegs[rs], immExt));
  endtask

  task automatic issueBad(input instrWord word);
    present(word, 1'b0, 5'd0, 33'd0);
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      instrValid = 1'b0;
      expValid   = 1'b0;
      expIllegal = 1'b0;
    end
  endtask

  // drop the strobe and wait for the answer to the last instruction
  task automatic settle();
    int cycles;
    idle(1);
    cycles = 0;
    while (!(resultValid || illegal) && cycles < 8) begin
      @(negedge clk);
      cycles++;
    end
    if (!(resultValid || illegal)) begin
      timeoutCount++;
      $display("Timed out at time %0t waiting for resultValid or illegal", $time);
    end
  endtask

  initial begin
    logic [31:0] bits;
    logic [4:0]  rd;
    instrWord    bad;
    lfsrState     = 32'hba8b;
    mismatchCount = 0;
    timeoutCount  = 0;
    rstN          = 1'b0;
    instrValid    = 1'b0;
    instr         = '0;
    expValid      = 1'b0;
    expIllegal    = 1'b0;
    expResult     = '0;
    expOvf        = 1'b0;
    for (int r = 0; r < numRegs; r++) begin
      modelRegs[r] = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    idle(4); // quiet outputs after reset
    issueR(opAdd, 5'd1, 5'd0, 5'd0);
    settle();

    for (int r = 1; r < numRegs; r++) begin
      issueI(opAdd, 5'(r), 5'd0, randImm());
    end
    for (int i = 0; i < 50; i++) begin
      bits = randBits(1);
      issueR(bits[0] ? opSub : opAdd, randReg(), randReg(), randReg());
    end
    settle();

    // doubling one in place reaches the most negative value, then minus one wraps to max
    issueI(opAdd, 5'd29, 5'd0, 16'd1);
    issueI(opAdd, 5'd30, 5'd0, 16'd1);
    for (int i = 0; i < 31; i++) begin
      issueR(opAdd, 5'd30, 5'd30, 5'd30);
    end
    issueR(opSub, 5'd31, 5'd30, 5'd29);
    issueR(opAdd, 5'd3, 5'd30, 5'd30);
    issueR(opSub, 5'd4, 5'd31, 5'd30);
    issueR(opAdd, 5'd5, 5'd31, 5'd29);
    issueR(opSub, 5'd6, 5'd0, 5'd30);
    settle();

    issueR(opSlt, 5'd1, 5'd30, 5'd29);
    issueR(opSlt, 5'd2, 5'd29, 5'd30);
    issueR(opSlt, 5'd3, 5'd29, 5'd29);
    issueR(opSlt, 5'd4, 5'd30, 5'd31);
    issueR(opSlt, 5'd5, 5'd31, 5'd30);
    issueI(opSlt, 5'd6, 5'd30, 16'h7fff);
    issueI(opSlt, 5'd7, 5'd31, 16'h8000);
    issueI(opSlt, 5'd8, 5'd29, 16'd1);
    for (int i = 0; i < 30; i++) begin
      bits = randBits(1);
      if (bits[0]) begin
        issueR(opSlt, randReg(), randReg(), randReg());
      end else begin
        issueI(opSlt, randReg(), randReg(), randImm());
      end
    end
    settle();

    for (int i = 0; i < 40; i++) begin
      issueR(randLogicOp(), randReg(), randReg(), randReg());
    end
    settle();

    // each instruction reads what the one before it wrote
    rd = randReg();
    for (int i = 0; i < 20; i++) begin
      bits = {27'd0, rd};
      rd   = randReg();
      issueR(randAnyOp(), rd, bits[4:0], randReg());
    end
    issueI(opAdd, 5'd0, 5'd29, 16'd5);
    issueR(opAdd, 5'd9, 5'd0, 5'd0);
    issueR(opOr, 5'd0, 5'd31, 5'd31);
    issueR(opAdd, 5'd10, 5'd0, 5'd29);
    settle();

    bad              = '0;
    bad.iType.opcode = 6'h3f;
    bad.iType.rd     = 5'd5;
    bad.iType.imm    = 16'h1234;
    issueBad(bad);
    settle();
    bad              = '0;
    bad.rType.opcode = opcodeR;
    bad.rType.rd     = 5'd6;
    bad.rType.rs     = 5'd31;
    bad.rType.funct  = 6'h01;
    issueBad(bad);
    issueR(opOr, 5'd7, 5'd5, 5'd0);
    issueR(opOr, 5'd8, 5'd6, 5'd0);
    settle();

    idle(2);
    $display("Error counts: %0d mismatches, %0d timeouts", mismatchCount, timeoutCount);
    if (mismatchCount == 0 && timeoutCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
design/aluPkg.sv
design/instrPkg.sv
design/rippleAdder.sv
design/alu.sv
design/regFile.sv
design/execCore.sv
tb/clockGen.sv
tb/execCoreTb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := execCoreTb
RTL_TOP    := execCore
FILELIST   := list.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
